/* hdl/link_monitor_pkg.sv */
`default_nettype none

package link_monitor_pkg;

  ////////////////////////////////////////////////////////////////////
  // data types
  ////////////////////////////////////////////////////////////////////

  typedef logic [7:0]  pixel_t;      // one colour channel
  typedef logic [11:0] burst_len_t;  // saturates at all ones
  typedef logic [20:0] rate_t;       // edges per window

  typedef enum logic [1:0] {
    ST_WAIT_LOCK = 2'd0,  // pll not yet locked
    ST_SETTLE    = 2'd1,  // power-up settle count
    ST_WAIT_INIT = 2'd2,  // waiting on video sink init
    ST_RUN       = 2'd3   // everything enabled
  } seq_state_e;

  ////////////////////////////////////////////////////////////////////
  // timing constants
  ////////////////////////////////////////////////////////////////////

  localparam int SETTLE_CYCLES = 10000;  // cycles spent in ST_SETTLE
  localparam int WINDOW_CYCLES = 1000;   // measurement window length
  localparam int SYNC_STAGES   = 2;      // flops per level synchronizer

  // counter widths derived from the periods above
  localparam int SETTLE_W = $clog2(SETTLE_CYCLES);
  localparam int WINDOW_W = $clog2(WINDOW_CYCLES);

endpackage

`default_nettype wire

/* hdl/startup_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module startup_seq (
  input  wire  sys_clk,
  input  wire  rstn_out,
  input  wire  i_pll_locked,
  input  wire  i_sink_init_done,
  output logic o_ready,
  output logic o_video_en,
  output logic o_mon_en,
  output logic o_window_tick,
  output logic o_rate_strobe
);
  import link_monitor_pkg::*;

  seq_state_e          state;
  seq_state_e          state_nxt;
  logic [SETTLE_W-1:0] settle_cnt;
  logic [WINDOW_W-1:0] win_cnt;
  logic                settle_done;
  logic                window_end;

  assign settle_done = (settle_cnt == SETTLE_W'(SETTLE_CYCLES - 1));  // last settle cycle
  assign window_end  = (win_cnt == WINDOW_W'(WINDOW_CYCLES - 1));

  ////////////////////////////////////////////////////////////////////
  // startup FSM
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      ST_WAIT_LOCK: begin
        if (i_pll_locked) state_nxt = ST_SETTLE;
      end
      ST_SETTLE: begin
        if (settle_done) state_nxt = ST_WAIT_INIT;
      end
      ST_WAIT_INIT: begin
        if (i_sink_init_done) state_nxt = ST_RUN;
      end
      ST_RUN: begin
        state_nxt = ST_RUN;
      end
      default: begin
        state_nxt = ST_WAIT_LOCK;
      end
    endcase
    // losing lock wins over everything
    if (!i_pll_locked) state_nxt = ST_WAIT_LOCK;
  end

  always_ff @(posedge sys_clk or negedge rstn_out) begin
    if (!rstn_out) begin
      state      <= ST_WAIT_LOCK;
      settle_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (state == ST_SETTLE) begin
        settle_cnt <= settle_cnt + 1'b1;  // cycles spent in ST_SETTLE
      end else begin
        settle_cnt <= '0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // measurement window timer
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge sys_clk or negedge rstn_out) begin
    if (!rstn_out) begin
      win_cnt       <= '0;
      o_rate_strobe <= 1'b0;
    end else begin
      o_rate_strobe <= o_window_tick;  // rates visible one cycle after tick
      if (state != ST_RUN || window_end) begin
        win_cnt <= '0;
      end else begin
        win_cnt <= win_cnt + 1'b1;
      end
    end
  end

  assign o_window_tick = (state == ST_RUN) && window_end;
  assign o_ready       = (state == ST_RUN);
  assign o_video_en    = (state == ST_RUN);
  assign o_mon_en      = (state == ST_RUN);

endmodule

`default_nettype wire

/* hdl/video_passthru.sv */
`timescale 1ns/1ps
`default_nettype none

module video_passthru (
  input  wire                     sys_clk,
  input  wire                     rstn_out,
  input  wire                     i_en,
  input  wire                     i_vs,
  input  wire                     i_hs,
  input  wire                     i_de,
  input  wire link_monitor_pkg::pixel_t i_r,
  input  wire link_monitor_pkg::pixel_t i_g,
  input  wire link_monitor_pkg::pixel_t i_b,
  output logic                    o_vs,
  output logic                    o_hs,
  output logic                    o_de,
  output link_monitor_pkg::pixel_t o_r,
  output link_monitor_pkg::pixel_t o_g,
  output link_monitor_pkg::pixel_t o_b
);

  // output register towards the video sink
  always_ff @(posedge sys_clk or negedge rstn_out) begin
    if (!rstn_out) begin
      o_vs <= 1'b0;
      o_hs <= 1'b0;
      o_de <= 1'b0;
      o_r  <= '0;
      o_g  <= '0;
      o_b  <= '0;
    end else if (i_en) begin
      o_vs <= i_vs;  // one cycle latency
      o_hs <= i_hs;
      o_de <= i_de;
      o_r  <= i_r;
      o_g  <= i_g;
      o_b  <= i_b;
    end else begin
      o_vs <= 1'b0;  // sink sees black, no syncs
      o_hs <= 1'b0;
      o_de <= 1'b0;
      o_r  <= '0;
      o_g  <= '0;
      o_b  <= '0;
    end
  end

endmodule

`default_nettype wire

/* hdl/burst_meter.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_meter (
  input  wire                          sys_clk,
  input  wire                          rstn_out,
  input  wire                          i_en,
  input  wire                          i_rx_valid,
  output link_monitor_pkg::burst_len_t o_burst_len,
  output logic                         o_burst_done
);
  import link_monitor_pkg::*;

  burst_len_t run_cnt;   // high time of the current burst
  logic       rx_prev;   // last sample of i_rx_valid
  logic       burst_end;

  assign burst_end = rx_prev && !i_rx_valid;  // first low after a high

  always_ff @(posedge sys_clk or negedge rstn_out) begin
    if (!rstn_out) begin
      run_cnt      <= '0;
      rx_prev      <= 1'b0;
      o_burst_len  <= '0;
      o_burst_done <= 1'b0;
    end else if (!i_en) begin
      run_cnt      <= '0;
      rx_prev      <= 1'b0;
      o_burst_done <= 1'b0;  // o_burst_len keeps its last value
    end else begin
      rx_prev      <= i_rx_valid;
      o_burst_done <= burst_end;
      if (i_rx_valid) begin
        if (run_cnt != '1) begin
          run_cnt <= run_cnt + 1'b1;  // stick at all ones
        end
      end else begin
        run_cnt <= '0;
      end
      if (burst_end) begin
        o_burst_len <= run_cnt;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/edge_rate_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module edge_rate_counter (
  input  wire                     sys_clk,
  input  wire                     rstn_out,
  input  wire                     i_en,
  input  wire                     i_window_tick,
  input  wire                     i_level,
  output link_monitor_pkg::rate_t o_rate
);
  import link_monitor_pkg::*;

  logic [SYNC_STAGES-1:0] sync_q;     // sync_q[0] samples the pin
  logic                   level_d;    // synchronized level, one cycle late
  logic                   rise;
  rate_t                  edge_cnt;

  ////////////////////////////////////////////////////////////////////
  // synchronizer and edge detect
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge sys_clk or negedge rstn_out) begin
    if (!rstn_out) begin
      sync_q  <= '0;
      level_d <= 1'b0;
    end else begin
      sync_q  <= {sync_q[SYNC_STAGES-2:0], i_level};
      level_d <= sync_q[SYNC_STAGES-1];
    end
  end

  assign rise = sync_q[SYNC_STAGES-1] && !level_d;

  ////////////////////////////////////////////////////////////////////
  // per-window count
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge sys_clk or negedge rstn_out) begin
    if (!rstn_out) begin
      edge_cnt <= '0;
      o_rate   <= '0;
    end else if (!i_en) begin
      edge_cnt <= '0;
      o_rate   <= '0;
    end else if (i_window_tick) begin
      o_rate   <= edge_cnt + rate_t'(rise);  // include the tick cycle's edge
      edge_cnt <= '0;
    end else if (rise) begin
      edge_cnt <= edge_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hdl/link_monitor_top.sv */
`timescale 1ns/1ps
`default_nettype none

module link_monitor_top (
  input  wire                          sys_clk,
  input  wire                          rstn_out,
  input  wire                          i_pll_locked,
  input  wire                          i_sink_init_done,
  // video in
  input  wire                          i_vs,
  input  wire                          i_hs,
  input  wire                          i_de,
  input  wire link_monitor_pkg::pixel_t     i_r,
  input  wire link_monitor_pkg::pixel_t     i_g,
  input  wire link_monitor_pkg::pixel_t     i_b,
  // monitored levels
  input  wire                          i_rx_valid,
  input  wire                          i_frame_vsync,
  // video out
  output wire                          o_vs,
  output wire                          o_hs,
  output wire                          o_de,
  output wire link_monitor_pkg::pixel_t     o_r,
  output wire link_monitor_pkg::pixel_t     o_g,
  output wire link_monitor_pkg::pixel_t     o_b,
  // status
  output wire                          o_ready,
  output wire link_monitor_pkg::burst_len_t o_burst_len,
  output wire                          o_burst_done,
  output wire link_monitor_pkg::rate_t      o_valid_rate,
  output wire link_monitor_pkg::rate_t      o_vsync_rate,
  output wire                          o_rate_strobe
);

  wire video_en;     // sequencer in ST_RUN
  wire mon_en;
  wire window_tick;  // end of measurement window

  ////////////////////////////////////////////////////////////////////
  // startup control
  ////////////////////////////////////////////////////////////////////

  startup_seq startup_seq_inst (
    .sys_clk          (sys_clk),
    .rstn_out         (rstn_out),
    .i_pll_locked     (i_pll_locked),
    .i_sink_init_done (i_sink_init_done),
    .o_ready          (o_ready),
    .o_video_en       (video_en),
    .o_mon_en         (mon_en),
    .o_window_tick    (window_tick),
    .o_rate_strobe    (o_rate_strobe)
  );

  video_passthru video_passthru_inst (
    .sys_clk  (sys_clk),
    .rstn_out (rstn_out),
    .i_en     (video_en),
    .i_vs     (i_vs),
    .i_hs     (i_hs),
    .i_de     (i_de),
    .i_r      (i_r),
    .i_g      (i_g),
    .i_b      (i_b),
    .o_vs     (o_vs),
    .o_hs     (o_hs),
    .o_de     (o_de),
    .o_r      (o_r),
    .o_g      (o_g),
    .o_b      (o_b)
  );

  ////////////////////////////////////////////////////////////////////
  // link monitors
  ////////////////////////////////////////////////////////////////////

  burst_meter burst_meter_inst (
    .sys_clk      (sys_clk),
    .rstn_out     (rstn_out),
    .i_en         (mon_en),
    .i_rx_valid   (i_rx_valid),   // taken as synchronous here
    .o_burst_len  (o_burst_len),
    .o_burst_done (o_burst_done)
  );

  edge_rate_counter valid_rate_inst (
    .sys_clk       (sys_clk),
    .rstn_out      (rstn_out),
    .i_en          (mon_en),
    .i_window_tick (window_tick),
    .i_level       (i_rx_valid),
    .o_rate        (o_valid_rate)
  );

  edge_rate_counter vsync_rate_inst (
    .sys_clk       (sys_clk),
    .rstn_out      (rstn_out),
    .i_en          (mon_en),
    .i_window_tick (window_tick),
    .i_level       (i_frame_vsync),
    .o_rate        (o_vsync_rate)
  );

endmodule

`default_nettype wire

/* include/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////////////////////////////////////////////////////////
// failure report, stops the run on the first mismatch
////////////////////////////////////////////////////////////////////////

task automatic check_fail(input string test_name, input string what,
                          input string exp_s, input string act_s);
  $display("CHECK FAILED: test %s, %s expected %s actual %s",
           test_name, what, exp_s, act_s);
  $display("*** TEST FAILED ***");
  $fatal(1, "stopping on first mismatch");
endtask

////////////////////////////////////////////////////////////////////////
// typed compares
////////////////////////////////////////////////////////////////////////

task automatic check_pixel(input string test_name, input string what,
                           input link_monitor_pkg::pixel_t exp,
                           input link_monitor_pkg::pixel_t act);
  if (act !== exp) check_fail(test_name, what, $sformatf("%0d", exp), $sformatf("%0d", act));
endtask

task automatic check_len(input string test_name, input string what,
                         input link_monitor_pkg::burst_len_t exp,
                         input link_monitor_pkg::burst_len_t act);
  if (act !== exp) check_fail(test_name, what, $sformatf("%0d", exp), $sformatf("%0d", act));
endtask

task automatic check_rate(input string test_name, input string what,
                          input link_monitor_pkg::rate_t exp,
                          input link_monitor_pkg::rate_t act);
  if (act !== exp) check_fail(test_name, what, $sformatf("%0d", exp), $sformatf("%0d", act));
endtask

task automatic check_bit(input string test_name, input string what,
                         input logic exp, input logic act);
  if (act !== exp) check_fail(test_name, what, $sformatf("%b", exp), $sformatf("%b", act));
endtask

`endif

/* verification/tb_link_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_link_monitor;
  import link_monitor_pkg::*;

  `include "tb_checks.svh"

  localparam int NUM_ROWS       = 6;
  localparam int TIMEOUT_CYCLES = 16 + SETTLE_CYCLES + 100 + (NUM_ROWS + 2) * WINDOW_CYCLES;

  // one row per measurement window, the last row stays empty
  string row_name   [NUM_ROWS] = '{"single", "short_many", "long", "mixed", "dense", "empty"};
  int    row_bursts [NUM_ROWS] = '{1, 20, 4, 10, 60, 0};
  int    row_len    [NUM_ROWS] = '{5, 3, 100, 40, 1, 0};
  int    row_gap    [NUM_ROWS] = '{4, 2, 20, 10, 1, 0};
  int    row_pulses [NUM_ROWS] = '{1, 10, 3, 25, 50, 0};

  logic       sys_clk = 1'b0;
  logic       rstn_out;
  logic       i_pll_locked, i_sink_init_done;
  logic       i_vs, i_hs, i_de;
  pixel_t     i_r, i_g, i_b;
  logic       i_rx_valid, i_frame_vsync;
  logic       o_vs, o_hs, o_de;
  pixel_t     o_r, o_g, o_b;
  logic       o_ready, o_burst_done, o_rate_strobe;
  burst_len_t o_burst_len;
  rate_t      o_valid_rate, o_vsync_rate;

  logic       exp_vs, exp_hs, exp_de;  // video word the DUT sampled last edge
  pixel_t     exp_r, exp_g, exp_b;
  string      cur_name;
  burst_len_t exp_len;
  int         done_cnt;
  int         cycle_cnt = 0;

  always #5 sys_clk = ~sys_clk;  // 10 ns period

  link_monitor_top link_monitor_top_inst (
    .sys_clk(sys_clk), .rstn_out(rstn_out),
    .i_pll_locked(i_pll_locked), .i_sink_init_done(i_sink_init_done),
    .i_vs(i_vs), .i_hs(i_hs), .i_de(i_de), .i_r(i_r), .i_g(i_g), .i_b(i_b),
    .i_rx_valid(i_rx_valid), .i_frame_vsync(i_frame_vsync),
    .o_vs(o_vs), .o_hs(o_hs), .o_de(o_de), .o_r(o_r), .o_g(o_g), .o_b(o_b),
    .o_ready(o_ready), .o_burst_len(o_burst_len), .o_burst_done(o_burst_done),
    .o_valid_rate(o_valid_rate), .o_vsync_rate(o_vsync_rate),
    .o_rate_strobe(o_rate_strobe)
  );

  ////////////////////////////////////////////////////////////////////
  // random video source and monitors
  ////////////////////////////////////////////////////////////////////

  initial begin
    i_vs = 1'b0;
    i_hs = 1'b0;
    i_de = 1'b0;
    i_r  = '0;
    i_g  = '0;
    i_b  = '0;
    forever begin
      @(posedge sys_clk);
      exp_vs <= i_vs;  // value sampled on this edge
      exp_hs <= i_hs;
      exp_de <= i_de;
      exp_r  <= i_r;
      exp_g  <= i_g;
      exp_b  <= i_b;
      i_vs   <= 1'($urandom);
      i_hs   <= 1'($urandom);
      i_de   <= 1'($urandom);
      i_r    <= pixel_t'($urandom);
      i_g    <= pixel_t'($urandom);
      i_b    <= pixel_t'($urandom);
    end
  end

  // nothing may leave the DUT before the sink reports init
  always @(negedge sys_clk) begin
    if (!i_sink_init_done) begin
      check_bit("idle", "o_ready", 1'b0, o_ready);
      check_bit("idle", "o_burst_done", 1'b0, o_burst_done);
      check_bit("idle", "o_rate_strobe", 1'b0, o_rate_strobe);
      check_bit("idle", "o_de", 1'b0, o_de);
      check_bit("idle", "o_vs", 1'b0, o_vs);
      check_bit("idle", "o_hs", 1'b0, o_hs);
      check_pixel("idle", "o_r", '0, o_r);
      check_pixel("idle", "o_g", '0, o_g);
      check_pixel("idle", "o_b", '0, o_b);
    end
  end

  always @(negedge sys_clk) begin
    if (o_burst_done) begin
      check_len(cur_name, "o_burst_len", exp_len, o_burst_len);
      done_cnt = done_cnt + 1;
    end
  end

  always @(posedge sys_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout: rate strobe or ready never arrived");
    end
  end

  ////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////

  task automatic drive_bursts(input int n, input int len, input int gap);
    for (int i = 0; i < n; i++) begin
      repeat (len) begin
        @(posedge sys_clk);
        i_rx_valid <= 1'b1;
      end
      repeat (gap) begin
        @(posedge sys_clk);
        i_rx_valid <= 1'b0;
      end
    end
  endtask

  task automatic drive_vsync_pulses(input int n);
    for (int i = 0; i < n; i++) begin
      repeat (2) begin
        @(posedge sys_clk);
        i_frame_vsync <= 1'b1;
      end
      repeat (3) begin
        @(posedge sys_clk);
        i_frame_vsync <= 1'b0;
      end
    end
  endtask

  task automatic check_window(input int bursts, input int pulses);
    @(negedge sys_clk);
    while (!o_rate_strobe) @(negedge sys_clk);
    check_rate(cur_name, "o_valid_rate", rate_t'(bursts), o_valid_rate);
    check_rate(cur_name, "o_vsync_rate", rate_t'(pulses), o_vsync_rate);
    check_rate(cur_name, "burst_done pulses", rate_t'(bursts), rate_t'(done_cnt));
    @(negedge sys_clk);
    check_bit(cur_name, "o_rate_strobe width", 1'b0, o_rate_strobe);  // single pulse
  endtask

  ////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(53));
    rstn_out         = 1'b0;
    i_pll_locked     = 1'b0;
    i_sink_init_done = 1'b0;
    i_rx_valid       = 1'b0;
    i_frame_vsync    = 1'b0;
    cur_name         = "idle";
    exp_len          = '0;
    done_cnt         = 0;
    repeat (16) @(posedge sys_clk);
    rstn_out <= 1'b1;

    drive_bursts(3, 4, 2);  // traffic the disabled monitors must ignore
    drive_vsync_pulses(2);
    repeat (4) @(posedge sys_clk);
    i_pll_locked <= 1'b1;
    cur_name = "startup";
    repeat (10) @(posedge sys_clk);
    i_sink_init_done <= 1'b1;  // arrives while the sequencer still settles
    // lock went high 10 cycles ago, ready is due SETTLE_CYCLES + 2 after it
    repeat (SETTLE_CYCLES - 8) begin
      @(negedge sys_clk);
      check_bit(cur_name, "o_ready before settle end", 1'b0, o_ready);
    end
    @(negedge sys_clk);
    check_bit(cur_name, "o_ready one cycle after init sampled", 1'b1, o_ready);

    cur_name = "video";
    repeat (200) begin
      @(negedge sys_clk);
      check_bit(cur_name, "o_vs", exp_vs, o_vs);
      check_bit(cur_name, "o_hs", exp_hs, o_hs);
      check_bit(cur_name, "o_de", exp_de, o_de);
      check_pixel(cur_name, "o_r", exp_r, o_r);
      check_pixel(cur_name, "o_g", exp_g, o_g);
      check_pixel(cur_name, "o_b", exp_b, o_b);
    end

    cur_name = "first_window";
    check_window(0, 0);  // aligns the loop to the window ticks

    for (int r = 0; r < NUM_ROWS; r++) begin
      cur_name = row_name[r];
      exp_len  = burst_len_t'(row_len[r]);
      done_cnt = 0;
      repeat (20) @(posedge sys_clk);  // keep clear of the last tick
      drive_bursts(row_bursts[r], row_len[r], row_gap[r]);
      drive_vsync_pulses(row_pulses[r]);
      check_window(row_bursts[r], row_pulses[r]);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
hdl/link_monitor_pkg.sv
hdl/startup_seq.sv
hdl/video_passthru.sv
hdl/burst_meter.sv
hdl/edge_rate_counter.sv
hdl/link_monitor_top.sv
verification/tb_link_monitor.sv

/* run_sim.sh */
#!/bin/sh
# compile the link monitor testbench with Verilator and run it
set -e

cd "$(dirname "$0")"
rm -rf obj_dir

verilator --binary --timing \
  -f all.f \
  --top-module tb_link_monitor \
  -o tb_link_monitor

# a $fatal in the testbench makes this step return a failing status
./obj_dir/tb_link_monitor
